//--- hdl/crc_pkg.sv
// Shared types for the CRC-16 frame checker; referenced by scoped names from every RTL module
package crc_pkg;

    // Widths that carry a meaning
    localparam int BYTE_W = 8;
    localparam int CRC_W  = 16;
    localparam int LEN_W  = 16;

    // One stream byte
    typedef logic [BYTE_W-1:0] byte_t;

    // CRC value or residue
    typedef logic [CRC_W-1:0] crc_t;

    // Frame byte count, saturates at all ones
    typedef logic [LEN_W-1:0] frame_len_t;

    // Frame controller states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        BODY   = 2'd1,
        FINISH = 2'd2
    } ctrl_state_t;

    // Result reported once per completed frame
    typedef struct packed {
        crc_t       crc;
        frame_len_t len;
        logic       ok;
    } frame_status_t;

    // Per-byte control from the controller to the datapath
    typedef struct packed {
        logic en;
        logic first;
    } byte_ctl_t;

endpackage

//--- hdl/crc16_engine.sv
// Two-stage byte-wise CRC-16 engine, MSB first, seeded from INIT on the first byte of a frame
`timescale 1ns/1ps

module crc16_engine #(
    parameter crc_pkg::crc_t POLY = 16'h1021,
    parameter crc_pkg::crc_t INIT = 16'hFFFF
) (
    input  logic               clk,
    input  logic               rst,
    input  crc_pkg::byte_ctl_t ctl,
    input  crc_pkg::byte_t     data,
    output crc_pkg::crc_t      crc
);

    // Stage one holds the CRC after the high nibble and the pending low nibble
    crc_pkg::crc_t s1_crc;
    logic [3:0]    s1_nib;
    logic          s1_vld;

    // Stage two result before it is registered, forwarded into stage one
    crc_pkg::crc_t s2_next;
    crc_pkg::crc_t s1_base;

    // Shift four data bits through the CRC, MSB first
    function automatic crc_pkg::crc_t fold_nibble(
        input crc_pkg::crc_t c,
        input logic [3:0]    nib
    );
        crc_pkg::crc_t r;
        r = c;
        for (int i = 3; i >= 0; i--) begin
            r = {r[14:0], 1'b0} ^ ((r[15] ^ nib[i]) ? POLY : crc_pkg::crc_t'(0));
        end
        return r;
    endfunction

    always_comb begin
        s2_next = s1_vld ? fold_nibble(s1_crc, s1_nib) : crc;
        // A new frame ignores whatever the previous frame left behind
        s1_base = ctl.first ? INIT : s2_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
            crc    <= INIT;
        end else begin
            s1_vld <= ctl.en;
            crc    <= s2_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.en) begin
            s1_crc <= fold_nibble(s1_base, data[7:4]);
            s1_nib <= data[3:0];
        end
    end

    // Controller only opens a frame on a byte it also accepts
    a_first_needs_en: assert property (
        @(posedge clk) disable iff (rst)
        ctl.first |-> ctl.en
    );

endmodule

//--- hdl/crc_frame_ctrl.sv
// Frame protocol FSM; accepts bytes, flags protocol errors and schedules the end-of-frame latch
`timescale 1ns/1ps

module crc_frame_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               data_valid,
    input  logic               sof,
    input  logic               eof,
    output crc_pkg::byte_ctl_t ctl,
    output logic               finish,
    output logic               proto_err
);

    crc_pkg::ctrl_state_t state;
    crc_pkg::ctrl_state_t state_nxt;

    logic open_frame;
    logic bad_byte;

    always_comb begin
        open_frame = (state == crc_pkg::BODY);

        // Bytes are taken when they open a frame or continue an open one
        ctl.en    = data_valid && (sof || open_frame);
        ctl.first = data_valid && sof;

        // Stray byte outside a frame, or sof that aborts an open frame
        bad_byte = data_valid && (sof ? open_frame : !open_frame);
    end

    always_comb begin
        state_nxt = state;
        if (ctl.en) begin
            state_nxt = eof ? crc_pkg::FINISH : crc_pkg::BODY;
        end else if (state == crc_pkg::FINISH) begin
            state_nxt = crc_pkg::IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= crc_pkg::IDLE;
            finish    <= 1'b0;
            proto_err <= 1'b0;
        end else begin
            state     <= state_nxt;
            // One extra stage so the latch lines up with the engine pipeline
            finish    <= (state == crc_pkg::FINISH);
            proto_err <= bad_byte;
        end
    end

    // A second finish in a row only follows a one-byte frame
    a_finish_single: assert property (
        @(posedge clk) disable iff (rst)
        finish && $past(finish) |-> $past(ctl.first && eof, 2)
    );

    // Each error pulse comes from its own byte that is dropped or opens a frame
    a_err_single: assert property (
        @(posedge clk) disable iff (rst)
        proto_err && $past(proto_err) |->
            $past(data_valid && (ctl.first || !ctl.en)) &&
            $past(data_valid && (ctl.first || !ctl.en), 2)
    );

endmodule

//--- hdl/crc_frame_status.sv
// Byte counter and end-of-frame result latch for CRC, length and residue check
`timescale 1ns/1ps

module crc_frame_status (
    input  logic                   clk,
    input  logic                   rst,
    input  crc_pkg::byte_ctl_t     ctl,
    input  logic                   finish,
    input  crc_pkg::crc_t          crc,
    output crc_pkg::frame_status_t status,
    output logic                   done
);

    // Running count of the open frame
    crc_pkg::frame_len_t cnt;

    // Count delayed one cycle, so it still holds the eof count when the next frame starts
    crc_pkg::frame_len_t len_hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (ctl.en) begin
            if (ctl.first) begin
                cnt <= crc_pkg::frame_len_t'(1);
            end else if (cnt != '1) begin
                cnt <= cnt + crc_pkg::frame_len_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        len_hold <= cnt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;
            done   <= 1'b0;
        end else begin
            done <= finish;
            if (finish) begin
                status.crc <= crc;
                status.len <= len_hold;
                // Zero residue when the sender's CRC rode along big-endian
                status.ok  <= (crc == '0);
            end
        end
    end

    // Two done cycles in a row only when a one-byte frame directly follows
    a_done_single: assert property (
        @(posedge clk) disable iff (rst)
        done && $past(done) |-> $past(ctl.first, 3)
    );

endmodule

//--- hdl/crc_frame_checker.sv
// Top level of the CRC-16 frame checker; connects the controller, CRC engine and status block
`timescale 1ns/1ps

module crc_frame_checker #(
    parameter crc_pkg::crc_t POLY = 16'h1021,
    parameter crc_pkg::crc_t INIT = 16'hFFFF
) (
    input  logic                   clk,
    input  logic                   rst,
    input  crc_pkg::byte_t         data,
    input  logic                   data_valid,
    input  logic                   sof,
    input  logic                   eof,
    output logic                   done,
    output crc_pkg::frame_status_t status,
    output logic                   proto_err
);

    crc_pkg::byte_ctl_t ctl;
    crc_pkg::crc_t      crc;
    logic               finish;

    crc_frame_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .data_valid (data_valid),
        .sof        (sof),
        .eof        (eof),
        .ctl        (ctl),
        .finish     (finish),
        .proto_err  (proto_err)
    );

    crc16_engine #(
        .POLY (POLY),
        .INIT (INIT)
    ) u_engine (
        .clk  (clk),
        .rst  (rst),
        .ctl  (ctl),
        .data (data),
        .crc  (crc)
    );

    crc_frame_status u_status (
        .clk    (clk),
        .rst    (rst),
        .ctl    (ctl),
        .finish (finish),
        .crc    (crc),
        .status (status),
        .done   (done)
    );

endmodule

//--- bench/crc_frame_checker_tb.sv
// Self-checking testbench for the CRC-16 frame checker; LFSR frames compared with a bitwise CRC model
`timescale 1ns/1ps

module crc_frame_checker_tb;

    localparam crc_pkg::crc_t POLY = 16'h1021;
    localparam crc_pkg::crc_t INIT = 16'hFFFF;
    localparam int DRAIN_LIMIT = 60;
    localparam int ERR_LIMIT   = 10;

    logic                   clk;
    logic                   rst;
    crc_pkg::byte_t         data;
    logic                   data_valid;
    logic                   sof;
    logic                   eof;
    logic                   done;
    crc_pkg::frame_status_t status;
    logic                   proto_err;

    logic [31:0]            lfsr;
    crc_pkg::byte_t         pay [0:63];
    // Expected results and the edge that accepted each eof byte
    crc_pkg::frame_status_t exp_q [$];
    int                     eof_q [$];
    crc_pkg::frame_status_t exp_st;
    int                     exp_cyc;

    int    cyc;
    int    err_pulses;
    int    checks;
    int    errors;
    int    tests;
    int    err_base;
    int    check_base;
    int    error_base;
    string test_name;

    crc_frame_checker #(
        .POLY (POLY),
        .INIT (INIT)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .data       (data),
        .data_valid (data_valid),
        .sof        (sof),
        .eof        (eof),
        .done       (done),
        .status     (status),
        .proto_err  (proto_err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Bit-serial CCITT reference over pay[0..n-1]
    function automatic crc_pkg::crc_t model_crc(input int n);
        crc_pkg::crc_t c;
        logic          fb;
        c = INIT;
        for (int k = 0; k < n; k++) begin
            for (int b = 7; b >= 0; b--) begin
                fb = c[15] ^ pay[k][b];
                c = {c[14:0], 1'b0};
                if (fb) begin
                    c = c ^ POLY;
                end
            end
        end
        return c;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected == actual) else begin
            $display("MISMATCH %s %s expected %0h actual %0h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        err_base   = err_pulses;
        check_base = checks;
        error_base = errors;
    endtask

    task automatic finish_test(input int exp_err);
        check_value("proto_err pulses", 32'(exp_err), 32'(err_pulses - err_base));
        tests++;
        $display("test %s: %0d checks, %0d errors", test_name, checks - check_base,
                 errors - error_base);
    endtask

    task automatic drive_byte(input crc_pkg::byte_t b, input logic s, input logic e);
        @(negedge clk);
        data       = b;
        data_valid = 1'b1;
        sof        = s;
        eof        = e;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        data       = 8'h00;
        data_valid = 1'b0;
        sof        = 1'b0;
        eof        = 1'b0;
    endtask

    task automatic fill_random(input int n);
        for (int k = 0; k < n; k++) begin
            pay[k] = crc_pkg::byte_t'(rand_bits(8));
        end
    endtask

    // Sends pay[0..n-1]; a closed frame queues its expected result at the eof byte
    task automatic send_frame(input int n, input bit gaps, input bit close,
                              input crc_pkg::crc_t exp_crc);
        crc_pkg::frame_status_t st;
        bit                     last;
        int                     g;
        for (int i = 0; i < n; i++) begin
            if (gaps && i > 0 && rand_bits(1) == 1) begin
                g = 1 + int'(rand_bits(2) % 3);
                repeat (g) drive_idle();
            end
            last = close && (i == n - 1);
            drive_byte(pay[i], i == 0, last);
            if (last) begin
                st.crc = exp_crc;
                st.len = crc_pkg::frame_len_t'(n);
                st.ok  = (exp_crc == 16'h0000);
                exp_q.push_back(st);
                eof_q.push_back(cyc + 1);
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            drive_idle();
            @(posedge clk);
            n++;
            if (n > DRAIN_LIMIT) begin
                $display("ERROR: %s timed out waiting for done", test_name);
                errors++;
                exp_q.delete();
                eof_q.delete();
            end
        end
    endtask

    task automatic wait_err(input int target);
        int n;
        n = 0;
        while (err_pulses < target) begin
            drive_idle();
            @(posedge clk);
            n++;
            if (n > ERR_LIMIT) begin
                $display("ERROR: %s timed out waiting for a proto_err pulse", test_name);
                errors++;
                break;
            end
        end
    endtask

    // Result monitor, sampled away from the active edge
    always @(negedge clk) begin
        if (!rst) begin
            if (proto_err) begin
                err_pulses++;
            end
            if (done) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: %s saw done with no frame outstanding", test_name);
                    errors++;
                end else begin
                    exp_st  = exp_q.pop_front();
                    exp_cyc = eof_q.pop_front();
                    check_value("crc", 32'(exp_st.crc), 32'(status.crc));
                    check_value("len", 32'(exp_st.len), 32'(status.len));
                    check_value("ok", 32'(exp_st.ok), 32'(status.ok));
                    check_value("done cycle", 32'(exp_cyc + 2), 32'(cyc));
                end
            end
        end
    end

    task automatic test_random();
        int n;
        start_test("random");
        for (int k = 0; k < 8; k++) begin
            n = 1 + int'(rand_bits(5) % 20);
            fill_random(n);
            send_frame(n, 1'b0, 1'b1, model_crc(n));
            repeat (int'(rand_bits(2))) drive_idle();
        end
        wait_drain();
        finish_test(0);
    endtask

    task automatic test_appended();
        int            n;
        int            bitpos;
        crc_pkg::crc_t c;
        start_test("appended");
        for (int k = 0; k < 4; k++) begin
            n = 1 + int'(rand_bits(5) % 18);
            fill_random(n);
            c = model_crc(n);
            pay[n]     = c[15:8];
            pay[n + 1] = c[7:0];
            send_frame(n + 2, 1'b0, 1'b1, 16'h0000);
            drive_idle();
            // Single flipped bit must break the residue
            bitpos = int'(rand_bits(8) % 32'((n + 2) * 8));
            pay[bitpos / 8] = pay[bitpos / 8] ^ (8'h01 << (bitpos % 8));
            send_frame(n + 2, 1'b0, 1'b1, model_crc(n + 2));
            drive_idle();
        end
        wait_drain();
        finish_test(0);
    endtask

    task automatic test_short();
        int n;
        start_test("back_to_back");
        for (int k = 0; k < 10; k++) begin
            n = (k < 2 || k % 3 == 0) ? 1 : 1 + int'(rand_bits(2));
            fill_random(n);
            send_frame(n, 1'b0, 1'b1, model_crc(n));
        end
        wait_drain();
        finish_test(0);
    endtask

    task automatic test_gaps();
        int n;
        start_test("gaps");
        for (int k = 0; k < 6; k++) begin
            n = 2 + int'(rand_bits(5) % 19);
            fill_random(n);
            send_frame(n, 1'b1, 1'b1, model_crc(n));
        end
        wait_drain();
        finish_test(0);
    endtask

    task automatic test_proto();
        int n;
        start_test("proto_err");
        // Stray byte while idle
        drive_byte(crc_pkg::byte_t'(rand_bits(8)), 1'b0, 1'b0);
        wait_err(err_base + 1);
        repeat (4) drive_idle();
        // Open a frame, then abort it with a new sof
        n = 3 + int'(rand_bits(3));
        fill_random(n);
        send_frame(n, 1'b0, 1'b0, 16'h0000);
        n = 1 + int'(rand_bits(5) % 20);
        fill_random(n);
        send_frame(n, 1'b0, 1'b1, model_crc(n));
        wait_drain();
        finish_test(2);
    endtask

    initial begin
        lfsr       = 32'h1e05;
        rst        = 1'b1;
        data       = 8'h00;
        data_valid = 1'b0;
        sof        = 1'b0;
        eof        = 1'b0;
        cyc        = 0;
        err_pulses = 0;
        checks     = 0;
        errors     = 0;
        tests      = 0;
        test_name  = "init";

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset");
        check_value("done", 32'h0, 32'(done));
        check_value("proto_err", 32'h0, 32'(proto_err));
        check_value("status crc", 32'h0, 32'(status.crc));
        check_value("status len", 32'h0, 32'(status.len));
        check_value("status ok", 32'h0, 32'(status.ok));
        finish_test(0);

        test_random();
        test_appended();
        test_short();
        test_gaps();
        test_proto();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/crc_pkg.sv
hdl/crc16_engine.sv
hdl/crc_frame_ctrl.sv
hdl/crc_frame_status.sv
hdl/crc_frame_checker.sv
bench/crc_frame_checker_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and fail when the log reports errors
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir "$log"
verilator --binary --timing --assert -f files.f --top-module crc_frame_checker_tb \
    -Mdir obj_dir -o sim > "$log" 2>&1 \
    && ./obj_dir/sim >> "$log" 2>&1 \
    || echo "Errors found" >> "$log"
cat "$log"
if grep -q "Errors found" "$log"; then
    exit 1
fi
exit 0
